/* daq.f */
src/daq_pkg.sv
src/sample_fifo.sv
src/mcu_reg_bank.sv
src/phase_meter.sv
src/conv_scheduler.sv
src/ad7606_reader.sv
src/daq_top.sv
tb/daq_props.sv
tb/tb_daq_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_daq_top
FILELIST  ?= daq.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '>>> FAIL' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tb_daq_top.sv */
`timescale 1ns/1ns

module tb_daq_top;
	import daq_pkg::*;

	localparam int RST_CYC      = 16;
	localparam int P_MIN        = 300;
	localparam int P_MAX        = 2000;
	localparam int N_SETS       = 20;	// conversions read while live
	localparam int N_FILL       = 30;	// conversions with no reads
	localparam int CONV_MAX_CYC = 600;	// divider plus adc latency and margin
	localparam int QUIET_CYC    = 64;
	localparam int RVALID_WAIT  = 8;
	localparam int LIMIT = RST_CYC + 400 + 3 * P_MAX
		+ (N_SETS + N_FILL + 2) * CONV_MAX_CYC + 600 * (RVALID_WAIT + 4);

	logic              AD_CLK_40M;
	logic              arst_n;
	logic              mcu_cs_n, mcu_we_n, mcu_rd_n;
	logic [ADDR_W-1:0] mcu_addr;
	data_t             mcu_wdata, mcu_rdata, adc_db;
	logic              mcu_rvalid, adc_busy, phase;
	logic              adc_convst, adc_cs_n, adc_rd_n;

	integer          seed = 32'hf2e84c07;
	int              check_cnt, err_cnt, other_cnt, cycle_cnt;
	int              conv_cnt, rd_idx, phase_p, phase_edges;
	logic            phase_run;
	data_t           exp_q [N_CH][$];	// words the adc model handed out
	logic [N_CH-1:0] exp_ovf;

	daq_top u_dut (
		.AD_CLK_40M   (AD_CLK_40M),
		.arst_n_i     (arst_n),
		.mcu_cs_n_i   (mcu_cs_n),
		.mcu_we_n_i   (mcu_we_n),
		.mcu_rd_n_i   (mcu_rd_n),
		.mcu_addr_i   (mcu_addr),
		.mcu_wdata_i  (mcu_wdata),
		.adc_db_i     (adc_db),
		.adc_busy_i   (adc_busy),
		.phase_i      (phase),
		.mcu_rdata_o  (mcu_rdata),
		.mcu_rvalid_o (mcu_rvalid),
		.adc_convst_o (adc_convst),
		.adc_cs_n_o   (adc_cs_n),
		.adc_rd_n_o   (adc_rd_n)
	);

	initial begin
		AD_CLK_40M = 1'b0;
		forever #10 AD_CLK_40M = ~AD_CLK_40M;
	end

	always @(posedge AD_CLK_40M) begin
		cycle_cnt++;
		if (cycle_cnt == LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display(">>> FAIL");
			$finish;
		end
	end

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	function automatic logic [ADDR_W-1:0] ch_addr(input int k);
		return ADDR_W'(ADDR_CH_BASE + 2 * k);
	endfunction

	// model status, valid only with the adc quiet
	function automatic data_t expected_status(input logic phase_err);
		data_t s;
		s = '0;
		for (int k = 0; k < N_CH; k++) begin
			s[k]     = exp_q[k].size() != 0;
			s[4 + k] = exp_ovf[k];
		end
		s[8] = phase_err;
		return s;
	endfunction

	task automatic compare_value(input string name, input data_t want, input data_t got);
		check_cnt++;
		if (want !== got) begin
			err_cnt++;
			$display("mismatch %s: expected 0x%04h, actual 0x%04h", name, want, got);
		end
	endtask

	task automatic push_expected(input int ch, input data_t w);
		if (exp_q[ch].size() < FIFO_DEPTH)
			exp_q[ch].push_back(w);
		else
			exp_ovf[ch] = 1'b1;	// word dropped by a full fifo
	endtask

	//////////////////////////////////////////////////
	// mcu bus cycles
	//////////////////////////////////////////////////
	task automatic mcu_write(input logic [ADDR_W-1:0] addr, input data_t data);
		@(posedge AD_CLK_40M);
		mcu_cs_n  <= 1'b0;
		mcu_we_n  <= 1'b0;
		mcu_addr  <= addr;
		mcu_wdata <= data;
		@(posedge AD_CLK_40M);
		mcu_cs_n <= 1'b1;
		mcu_we_n <= 1'b1;
	endtask

	task automatic mcu_read(input logic [ADDR_W-1:0] addr, output data_t data);
		int waited;
		waited = 0;
		data   = '0;
		@(posedge AD_CLK_40M);
		mcu_cs_n <= 1'b0;
		mcu_rd_n <= 1'b0;
		mcu_addr <= addr;
		@(posedge AD_CLK_40M);
		mcu_cs_n <= 1'b1;	// strobe held one cycle only
		mcu_rd_n <= 1'b1;
		@(negedge AD_CLK_40M);
		while (!mcu_rvalid && waited < RVALID_WAIT) begin
			@(negedge AD_CLK_40M);
			waited++;
		end
		if (mcu_rvalid) begin
			data = mcu_rdata;
		end else begin
			other_cnt++;
			$display("error: no read response for address 0x%03h", addr);
		end
	endtask

	task automatic check_channel(input int ch, input string name);
		data_t got;
		mcu_read(ch_addr(ch), got);
		if (exp_q[ch].size() == 0) begin
			other_cnt++;
			$display("error: %s got 0x%04h from channel %0d with nothing expected",
				name, got, ch + 1);
		end else begin
			compare_value(name, exp_q[ch].pop_front(), got);
		end
	endtask

	task automatic wait_adc_quiet();
		int quiet;
		quiet = 0;
		while (quiet < QUIET_CYC) begin
			@(negedge AD_CLK_40M);
			if (adc_convst && adc_rd_n && !adc_busy)
				quiet++;
			else
				quiet = 0;
		end
	endtask

	//////////////////////////////////////////////////
	// adc and key-phase models
	//////////////////////////////////////////////////
	initial begin : adc_conv_model
		logic convst_d;
		logic fell;
		int   dly;
		int   hold;
		convst_d = 1'b1;
		forever begin
			@(negedge AD_CLK_40M);
			fell     = convst_d && !adc_convst;
			convst_d = adc_convst;
			if (fell) begin
				conv_cnt++;
				rd_idx = 0;
				dly    = rand_range(1, 4);
				hold   = rand_range(5, 20);
				repeat (dly) @(posedge AD_CLK_40M);
				adc_busy <= 1'b1;
				repeat (hold) @(posedge AD_CLK_40M);
				adc_busy <= 1'b0;
			end
		end
	end

	initial begin : adc_read_model
		logic  rd_d;
		logic  fell;
		data_t w;
		rd_d = 1'b1;
		forever begin
			@(negedge AD_CLK_40M);
			if (adc_cs_n !== adc_rd_n) begin
				other_cnt++;
				$display("error: adc cs_n and rd_n differ at %0t", $time);
			end
			fell = rd_d && !adc_rd_n;
			rd_d = adc_rd_n;
			if (fell) begin
				w = data_t'($random(seed));
				push_expected(rd_idx % N_CH, w);
				rd_idx++;
				@(posedge AD_CLK_40M);
				adc_db <= w;	// stable well before the latch edge
			end
		end
	end

	initial begin : phase_gen
		int hi;
		while (phase_run !== 1'b1)
			@(posedge AD_CLK_40M);
		hi = phase_p / 2;
		forever begin
			repeat (phase_p - hi) @(posedge AD_CLK_40M);
			phase <= 1'b1;
			phase_edges++;
			repeat (hi) @(posedge AD_CLK_40M);
			phase <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////
	initial begin : main
		data_t rd;
		data_t sdiv;
		int    sets;
		int    conv_start;
		mcu_cs_n  = 1'b1;
		mcu_we_n  = 1'b1;
		mcu_rd_n  = 1'b1;
		mcu_addr  = '0;
		mcu_wdata = '0;
		adc_db    = '0;
		adc_busy  = 1'b0;
		phase     = 1'b0;
		phase_run = 1'b0;
		exp_ovf   = '0;
		arst_n    = 1'b0;
		repeat (RST_CYC) @(posedge AD_CLK_40M);
		arst_n <= 1'b1;

		mcu_read(ADDR_VERSION, rd);
		compare_value("version", 16'h1000, rd);
		mcu_read(ADDR_STATUS, rd);
		compare_value("status_after_reset", 16'h0100, rd);

		sdiv = data_t'(rand_range(40, 239));	// below the shortest phase period
		mcu_write(ADDR_SAMPLE_DIV, sdiv);
		mcu_read(ADDR_SAMPLE_DIV, rd);
		compare_value("sample_div", sdiv, rd);

		phase_p   = rand_range(P_MIN, P_MAX);
		phase_run = 1'b1;
		while (phase_edges < 2)
			@(posedge AD_CLK_40M);
		repeat (4) @(posedge AD_CLK_40M);	// sync and latch delay
		mcu_read(ADDR_PHASE_L, rd);
		compare_value("phase_l", data_t'(phase_p), rd);
		mcu_read(ADDR_PHASE_H, rd);
		compare_value("phase_h", data_t'(phase_p >> 16), rd);
		mcu_read(ADDR_STATUS, rd);
		compare_value("phase_error_clear", 16'h0000, rd & 16'h0100);

		// period measured, so only the enable bit holds the scheduler back
		repeat (200) @(posedge AD_CLK_40M);
		mcu_read(ADDR_STATUS, rd);
		compare_value("nempty_while_disabled", 16'h0000, rd & 16'h000F);

		mcu_write(ADDR_CTRL, 16'h0001);
		sets = 0;
		while (sets < N_SETS) begin
			mcu_read(ADDR_STATUS, rd);
			compare_value("ovf_during_reads", 16'h0000, rd & 16'h00F0);
			if (rd[3:0] != 4'h0) begin
				for (int k = 0; k < N_CH; k++)
					check_channel(k, "live_sample");
				sets++;
			end
		end
		mcu_write(ADDR_CTRL, 16'h0000);
		wait_adc_quiet();
		do begin
			mcu_read(ADDR_STATUS, rd);
			if (rd[3:0] != 4'h0)
				for (int k = 0; k < N_CH; k++)
					check_channel(k, "drain_sample");
		end while (rd[3:0] != 4'h0);
		for (int k = 0; k < N_CH; k++)
			compare_value("words_left", 16'h0000, data_t'(exp_q[k].size()));

		conv_start = conv_cnt;
		mcu_write(ADDR_CTRL, 16'h0001);
		while (conv_cnt - conv_start < N_FILL)
			@(posedge AD_CLK_40M);
		mcu_write(ADDR_CTRL, 16'h0000);
		wait_adc_quiet();
		for (int k = 0; k < N_CH; k++)
			for (int i = 0; i < FIFO_DEPTH; i++)
				check_channel(k, "fill_sample");
		mcu_read(ch_addr(0), rd);
		compare_value("empty_channel", 16'h0000, rd);
		mcu_read(ADDR_STATUS, rd);
		compare_value("status_overflow", expected_status(1'b0), rd);

		mcu_write(ADDR_CTRL, 16'h0002);
		exp_ovf = '0;
		for (int k = 0; k < N_CH; k++)
			exp_q[k].delete();
		mcu_read(ADDR_STATUS, rd);
		compare_value("status_after_clr", expected_status(1'b0), rd);
		mcu_read(ADDR_CTRL, rd);
		compare_value("ctrl_after_clr", 16'h0000, rd);

		$display("summary: %0d checks, %0d mismatches, %0d other errors",
			check_cnt, err_cnt, other_cnt);
		if (err_cnt == 0 && other_cnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* tb/daq_props.sv */
`timescale 1ns/1ns

module daq_props (
	input logic AD_CLK_40M,
	input logic arst_n_i,
	input logic adc_busy_i,
	input logic adc_convst_o,
	input logic adc_rd_n_o,
	input logic sample_valid_o
);

	// new conversion only on an idle adc
	a_convst_idle: assert property (@(posedge AD_CLK_40M) disable iff (!arst_n_i)
		$fell(adc_convst_o) |-> !adc_busy_i)
		else $error("convst fell while busy was high");

	a_rd_after_busy: assert property (@(posedge AD_CLK_40M) disable iff (!arst_n_i)
		!adc_rd_n_o |-> !adc_busy_i)
		else $error("rd_n low while busy was high");

	a_sample_pulse: assert property (@(posedge AD_CLK_40M) disable iff (!arst_n_i)
		sample_valid_o |=> !sample_valid_o)
		else $error("sample_valid held longer than one cycle");

endmodule

bind ad7606_reader daq_props u_props (
	.AD_CLK_40M     (AD_CLK_40M),
	.arst_n_i       (arst_n_i),
	.adc_busy_i     (adc_busy_i),
	.adc_convst_o   (adc_convst_o),
	.adc_rd_n_o     (adc_rd_n_o),
	.sample_valid_o (sample_valid_o)
);

/* src/daq_top.sv */
`timescale 1ns/1ns

module daq_top (
	input  logic                         AD_CLK_40M,
	input  logic                         arst_n_i,
	input  logic                         mcu_cs_n_i,
	input  logic                         mcu_we_n_i,
	input  logic                         mcu_rd_n_i,
	input  logic [daq_pkg::ADDR_W-1:0]   mcu_addr_i,
	input  daq_pkg::data_t               mcu_wdata_i,
	input  daq_pkg::data_t               adc_db_i,
	input  logic                         adc_busy_i,
	input  logic                         phase_i,
	output daq_pkg::data_t               mcu_rdata_o,
	output logic                         mcu_rvalid_o,
	output logic                         adc_convst_o,
	output logic                         adc_cs_n_o,
	output logic                         adc_rd_n_o
);
	import daq_pkg::*;

	mcu_req_t              mcu_req;
	period_t               period;
	logic                  period_valid;
	logic                  phase_edge;
	data_t                 sample_div;
	logic                  enable;
	logic                  fifo_clr;
	logic                  conv_valid;
	logic                  conv_ready;
	sample_set_t           sample;
	logic                  sample_valid;
	data_t [N_CH-1:0]      fifo_head;
	logic [N_CH-1:0]       fifo_nempty;
	logic [N_CH-1:0]       fifo_ovf;
	logic [N_CH-1:0]       fifo_pop;

	assign mcu_req = '{cs: ~mcu_cs_n_i, we: ~mcu_we_n_i, rd: ~mcu_rd_n_i,
		addr: mcu_addr_i, wdata: mcu_wdata_i};	// pins to active high

	mcu_reg_bank u_regs (
		.AD_CLK_40M     (AD_CLK_40M),
		.arst_n_i       (arst_n_i),
		.req_i          (mcu_req),
		.period_i       (period),
		.period_valid_i (period_valid),
		.fifo_head_i    (fifo_head),
		.fifo_nempty_i  (fifo_nempty),
		.fifo_ovf_i     (fifo_ovf),
		.rdata_o        (mcu_rdata_o),
		.rvalid_o       (mcu_rvalid_o),
		.sample_div_o   (sample_div),
		.enable_o       (enable),
		.fifo_clr_o     (fifo_clr),
		.pop_o          (fifo_pop)
	);

	phase_meter u_phase (
		.AD_CLK_40M     (AD_CLK_40M),
		.arst_n_i       (arst_n_i),
		.phase_i        (phase_i),
		.period_o       (period),
		.period_valid_o (period_valid),
		.edge_o         (phase_edge)
	);

	conv_scheduler u_sched (
		.AD_CLK_40M     (AD_CLK_40M),
		.arst_n_i       (arst_n_i),
		.enable_i       (enable),
		.period_valid_i (period_valid),
		.edge_i         (phase_edge),
		.sample_div_i   (sample_div),
		.conv_ready_i   (conv_ready),
		.conv_valid_o   (conv_valid)
	);

	ad7606_reader u_adc (
		.AD_CLK_40M     (AD_CLK_40M),
		.arst_n_i       (arst_n_i),
		.conv_valid_i   (conv_valid),
		.adc_db_i       (adc_db_i),
		.adc_busy_i     (adc_busy_i),
		.conv_ready_o   (conv_ready),
		.adc_convst_o   (adc_convst_o),
		.adc_cs_n_o     (adc_cs_n_o),
		.adc_rd_n_o     (adc_rd_n_o),
		.sample_o       (sample),
		.sample_valid_o (sample_valid)
	);

	//////////////////////////////////////////////////
	// per-channel sample buffers
	//////////////////////////////////////////////////
	for (genvar g = 0; g < N_CH; g++) begin : g_fifo
		sample_fifo u_fifo (
			.AD_CLK_40M (AD_CLK_40M),
			.arst_n_i   (arst_n_i),
			.clr_i      (fifo_clr),
			.wr_i       (sample_valid),
			.wdata_i    (sample.ch[g]),
			.pop_i      (fifo_pop[g]),
			.head_o     (fifo_head[g]),
			.nempty_o   (fifo_nempty[g]),
			.ovf_o      (fifo_ovf[g])
		);
	end

endmodule

/* src/ad7606_reader.sv */
`timescale 1ns/1ns

module ad7606_reader (
	input  logic                AD_CLK_40M,
	input  logic                arst_n_i,
	input  logic                conv_valid_i,
	input  daq_pkg::data_t      adc_db_i,
	input  logic                adc_busy_i,
	output logic                conv_ready_o,
	output logic                adc_convst_o,
	output logic                adc_cs_n_o,
	output logic                adc_rd_n_o,
	output daq_pkg::sample_set_t sample_o,
	output logic                sample_valid_o
);
	import daq_pkg::*;

	localparam int CNT_W = 4;
	localparam int CH_W  = $clog2(N_CH);

	typedef enum logic [2:0] {
		S_IDLE,
		S_CONVST,
		S_WAIT_BH,
		S_WAIT_BL,
		S_READ
	} state_t;

	state_t           state_q;
	logic [CNT_W-1:0] cnt_q;
	logic [CH_W-1:0]  ch_q;
	logic             rd_low;
	logic             rd_last;

	// rd_n low for RD_CYC cycles, then one high cycle between words
	assign rd_low  = (state_q == S_READ) && (cnt_q < CNT_W'(RD_CYC));
	assign rd_last = (state_q == S_READ) && (cnt_q == CNT_W'(RD_CYC - 1));

	assign conv_ready_o = state_q == S_IDLE;
	assign adc_convst_o = state_q != S_CONVST;
	assign adc_cs_n_o   = ~rd_low;
	assign adc_rd_n_o   = ~rd_low;

	//////////////////////////////////////////////////
	// conversion and readout FSM
	//////////////////////////////////////////////////
	always_ff @(posedge AD_CLK_40M or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q        <= S_IDLE;
			cnt_q          <= '0;
			ch_q           <= '0;
			sample_valid_o <= 1'b0;
		end else begin
			sample_valid_o <= 1'b0;
			case (state_q)
				S_IDLE: begin
					cnt_q <= '0;
					if (conv_valid_i)
						state_q <= S_CONVST;
				end
				S_CONVST: begin
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == CNT_W'(CONVST_CYC - 1))
						state_q <= S_WAIT_BH;
				end
				S_WAIT_BH: begin
					if (adc_busy_i)
						state_q <= S_WAIT_BL;
				end
				S_WAIT_BL: begin
					ch_q  <= '0;
					cnt_q <= '0;
					if (!adc_busy_i)
						state_q <= S_READ;	// conversion done
				end
				S_READ: begin
					if (rd_last && ch_q == CH_W'(N_CH - 1)) begin
						state_q        <= S_IDLE;
						sample_valid_o <= 1'b1;
					end else if (cnt_q == CNT_W'(RD_CYC)) begin
						cnt_q <= '0;	// gap cycle done
						ch_q  <= ch_q + 1'b1;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge AD_CLK_40M) begin
		if (rd_last)
			sample_o.ch[ch_q] <= adc_db_i;	// last low cycle of rd_n
	end

endmodule

/* src/conv_scheduler.sv */
`timescale 1ns/1ns

module conv_scheduler (
	input  logic           AD_CLK_40M,
	input  logic           arst_n_i,
	input  logic           enable_i,
	input  logic           period_valid_i,
	input  logic           edge_i,
	input  daq_pkg::data_t sample_div_i,
	input  logic           conv_ready_i,
	output logic           conv_valid_o
);
	import daq_pkg::*;

	data_t cnt_q;
	logic  run;
	logic  advance;
	logic  wrap;
	logic  xfer;

	assign run     = enable_i & period_valid_i;
	assign advance = run & (~conv_valid_o | conv_ready_i);	// stall while blocked
	assign wrap    = cnt_q == sample_div_i;
	assign xfer    = conv_valid_o & conv_ready_i;

	//////////////////////////////////////////////////
	// divider, one request per sample_div+1 cycles
	//////////////////////////////////////////////////
	always_ff @(posedge AD_CLK_40M or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q <= '0;
		end else if (edge_i || !run) begin
			cnt_q <= '0;	// realign to key phase
		end else if (advance) begin
			cnt_q <= wrap ? '0 : cnt_q + 1'b1;
		end
	end

	always_ff @(posedge AD_CLK_40M or negedge arst_n_i) begin
		if (!arst_n_i)
			conv_valid_o <= 1'b0;
		else if (advance && wrap && !edge_i)
			conv_valid_o <= 1'b1;
		else if (xfer)
			conv_valid_o <= 1'b0;
	end

endmodule

/* src/phase_meter.sv */
`timescale 1ns/1ns

module phase_meter (
	input  logic             AD_CLK_40M,
	input  logic             arst_n_i,
	input  logic             phase_i,
	output daq_pkg::period_t period_o,
	output logic             period_valid_o,
	output logic             edge_o
);
	import daq_pkg::*;

	logic    ph_meta;
	logic    ph_sync;
	logic    ph_dly;
	logic    seen_edge;	// first rising edge already passed
	period_t cnt_q;

	always_ff @(posedge AD_CLK_40M or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ph_meta <= 1'b0;
			ph_sync <= 1'b0;
			ph_dly  <= 1'b0;
		end else begin
			ph_meta <= phase_i;	// async key-phase input
			ph_sync <= ph_meta;
			ph_dly  <= ph_sync;
		end
	end

	assign edge_o = ph_sync & ~ph_dly;

	// cnt_q equals cycles since the last edge
	always_ff @(posedge AD_CLK_40M or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q          <= '0;
			seen_edge      <= 1'b0;
			period_o       <= '0;
			period_valid_o <= 1'b0;
		end else if (edge_o) begin
			cnt_q     <= period_t'(1);
			seen_edge <= 1'b1;
			if (seen_edge) begin
				period_o       <= cnt_q;
				period_valid_o <= 1'b1;	// held until reset
			end
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

endmodule

/* src/mcu_reg_bank.sv */
`timescale 1ns/1ns

module mcu_reg_bank (
	input  logic                                AD_CLK_40M,
	input  logic                                arst_n_i,
	input  daq_pkg::mcu_req_t                   req_i,
	input  daq_pkg::period_t                    period_i,
	input  logic                                period_valid_i,
	input  daq_pkg::data_t [daq_pkg::N_CH-1:0]  fifo_head_i,
	input  logic [daq_pkg::N_CH-1:0]            fifo_nempty_i,
	input  logic [daq_pkg::N_CH-1:0]            fifo_ovf_i,
	output daq_pkg::data_t                      rdata_o,
	output logic                                rvalid_o,
	output daq_pkg::data_t                      sample_div_o,
	output logic                                enable_o,
	output logic                                fifo_clr_o,
	output logic [daq_pkg::N_CH-1:0]            pop_o
);
	import daq_pkg::*;

	data_t      sample_div_q;
	ctrl_word_u ctrl_q;
	data_t      status_word;
	data_t      rd_word;
	logic       wr_hit;
	logic       rd_hit;

	assign wr_hit = req_i.cs & req_i.we;
	assign rd_hit = req_i.cs & req_i.rd;

	// nempty in bits 3:0, sticky ovf in 7:4, phase error at 8
	assign status_word = data_t'({~period_valid_i, fifo_ovf_i, fifo_nempty_i});

	//////////////////////////////////////////////////
	// write side
	//////////////////////////////////////////////////
	always_ff @(posedge AD_CLK_40M or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sample_div_q <= '0;
			ctrl_q.raw   <= '0;
		end else begin
			if (wr_hit && req_i.addr == ADDR_SAMPLE_DIV)
				sample_div_q <= req_i.wdata;
			if (wr_hit && req_i.addr == ADDR_CTRL)
				ctrl_q.raw <= req_i.wdata;
			else
				ctrl_q.f.fifo_clr <= 1'b0;	// one cycle pulse
		end
	end

	assign sample_div_o = sample_div_q;
	assign enable_o     = ctrl_q.f.enable;
	assign fifo_clr_o   = ctrl_q.f.fifo_clr;

	//////////////////////////////////////////////////
	// read side
	//////////////////////////////////////////////////
	always_comb begin
		rd_word = '0;
		pop_o   = '0;
		if (rd_hit) begin
			case (req_i.addr)
				ADDR_VERSION:    rd_word = VERSION_WORD;
				ADDR_SAMPLE_DIV: rd_word = sample_div_q;
				ADDR_PHASE_L:    rd_word = period_i[DATA_W-1:0];
				ADDR_PHASE_H:    rd_word = period_i[PERIOD_W-1:DATA_W];
				ADDR_CTRL:       rd_word = ctrl_q.raw;
				ADDR_STATUS:     rd_word = status_word;
				default:         rd_word = '0;
			endcase
			for (int k = 0; k < N_CH; k++) begin
				if (req_i.addr == ADDR_W'(ADDR_CH_BASE + 2 * k)) begin
					rd_word  = fifo_nempty_i[k] ? fifo_head_i[k] : '0;	// empty reads zero
					pop_o[k] = fifo_nempty_i[k];	// pop with the same edge
				end
			end
		end
	end

	always_ff @(posedge AD_CLK_40M or negedge arst_n_i) begin
		if (!arst_n_i)
			rvalid_o <= 1'b0;
		else
			rvalid_o <= rd_hit;
	end

	always_ff @(posedge AD_CLK_40M) begin
		rdata_o <= rd_word;
	end

endmodule

/* src/sample_fifo.sv */
`timescale 1ns/1ns

module sample_fifo (
	input  logic           AD_CLK_40M,
	input  logic           arst_n_i,
	input  logic           clr_i,
	input  logic           wr_i,
	input  daq_pkg::data_t wdata_i,
	input  logic           pop_i,
	output daq_pkg::data_t head_o,
	output logic           nempty_o,
	output logic           ovf_o
);
	import daq_pkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	data_t            mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             full;
	logic             push;
	logic             pop;

	assign full     = count == (PTR_W + 1)'(FIFO_DEPTH);
	assign nempty_o = count != '0;
	assign push     = wr_i & ~full;	// full fifo drops the word
	assign pop      = pop_i & nempty_o;
	assign head_o   = mem[rd_ptr];

	always_ff @(posedge AD_CLK_40M or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			ovf_o  <= 1'b0;
		end else if (clr_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			ovf_o  <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
			if (wr_i && full)
				ovf_o <= 1'b1;	// sticky until clear
		end
	end

	always_ff @(posedge AD_CLK_40M) begin
		if (push)
			mem[wr_ptr] <= wdata_i;
	end

endmodule

/* src/daq_pkg.sv */
package daq_pkg;

	//////////////////////////////////////////////////
	// widths and sizes
	//////////////////////////////////////////////////
	localparam int DATA_W     = 16;	// mcu and adc word
	localparam int ADDR_W     = 9;	// mcu address bus
	localparam int N_CH       = 4;	// adc channels in use
	localparam int FIFO_DEPTH = 16;	// words per channel
	localparam int PERIOD_W   = 32;	// key-phase period counter

	localparam logic [DATA_W-1:0] VERSION_WORD = 16'h1000;

	localparam int CONVST_CYC = 2;	// convst low time
	localparam int RD_CYC     = 2;	// rd_n low time per word

	//////////////////////////////////////////////////
	// register map, byte offsets on the mcu bus
	//////////////////////////////////////////////////
	localparam logic [ADDR_W-1:0] ADDR_VERSION    = 9'h000;
	localparam logic [ADDR_W-1:0] ADDR_SAMPLE_DIV = 9'h002;
	localparam logic [ADDR_W-1:0] ADDR_PHASE_L    = 9'h00A;
	localparam logic [ADDR_W-1:0] ADDR_PHASE_H    = 9'h00C;
	localparam logic [ADDR_W-1:0] ADDR_CTRL       = 9'h00E;
	localparam logic [ADDR_W-1:0] ADDR_STATUS     = 9'h014;
	localparam logic [ADDR_W-1:0] ADDR_CH_BASE    = 9'h016;	// ch k at base + 2k

	typedef logic [DATA_W-1:0]   data_t;
	typedef logic [PERIOD_W-1:0] period_t;

	// one mcu bus cycle, strobes already active high
	typedef struct packed {
		logic              cs;
		logic              we;
		logic              rd;
		logic [ADDR_W-1:0] addr;
		data_t             wdata;
	} mcu_req_t;

	// one conversion result, ch[0] is channel 1
	typedef struct packed {
		data_t [N_CH-1:0] ch;
	} sample_set_t;

	typedef struct packed {
		logic [DATA_W-3:0] rsvd;
		logic              fifo_clr;	// self clearing
		logic              enable;	// sampling on
	} ctrl_fields_t;

	typedef union packed {
		data_t        raw;
		ctrl_fields_t f;
	} ctrl_word_u;

endpackage
